//--- rtl/ipod_settings.svh
`ifndef IPOD_SETTINGS_SVH
`define IPOD_SETTINGS_SVH

// ====================
// Flash and sample widths
// ====================
`define FLASH_ADDR_W 23
`define FLASH_DATA_W 32
`define SAMPLE_W 16
`define FLASH_LAST_ADDR 23'h7FFFF

// Sample rate divider, in CLK_50M cycles per sample
`define SAMPLE_DIV_DEFAULT 1136
`define SAMPLE_DIV_MIN 64
`define SAMPLE_DIV_MAX 65535
`define SPEED_STEP 16
`define SPEED_REPEAT_CYCLES 5000000

// PS/2 set 2 make codes
`define KEY_PLAY 8'h24
`define KEY_PAUSE 8'h23
`define KEY_FORWARD 8'h2B
`define KEY_BACKWARD 8'h32
`define KEY_RESTART 8'h2D

// Front panel
`define LED_BAR_W 8
`define HEX_DIGITS 6

`endif

//--- rtl/player_pkg.sv
`include "ipod_settings.svh"

package player_pkg;

  // ====================
  // Playback control
  // ====================
  typedef enum logic {
    play_paused  = 1'b0,
    play_playing = 1'b1
  } play_state_e;

  // Keyboard command after scan code decode
  typedef enum logic [2:0] {
    cmd_none     = 3'd0,
    cmd_play     = 3'd1,
    cmd_pause    = 3'd2,
    cmd_forward  = 3'd3,
    cmd_backward = 3'd4,
    cmd_restart  = 3'd5
  } key_cmd_e;

  // One sample request from the control FSM
  typedef struct packed {
    logic                     valid;
    logic                     need_read;
    logic [`FLASH_ADDR_W-1:0] addr;
    logic                     half;
  } fetch_req_t;

  // ====================
  // Flash bus
  // ====================
  typedef struct packed {
    logic                     read;
    logic [`FLASH_ADDR_W-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic                     waitrequest;
    logic                     readdatavalid;
    logic [`FLASH_DATA_W-1:0] readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic                 strobe;
    logic [`SAMPLE_W-1:0] data;
  } sample_t;

endpackage

//--- rtl/panel_pkg.sv
`include "ipod_settings.svh"

package panel_pkg;

  // ====================
  // Front panel outputs
  // ====================

  // Volume bar, bit 0 is the lowest LED
  typedef logic [`LED_BAR_W-1:0] led_bar_t;

  // Segment order g..a, active low
  // Digit 0 is the least significant nibble
  typedef logic [`HEX_DIGITS-1:0][6:0] hex_digits_t;

endpackage

//--- rtl/fetch_control.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module fetch_control (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic [7:0]             kbd_scan_code,
  input  logic                   kbd_data_ready,
  input  logic                   sample_tick,
  output player_pkg::fetch_req_t fetch_req
);

  localparam logic [`FLASH_ADDR_W-1:0] last_addr = `FLASH_LAST_ADDR;

  player_pkg::key_cmd_e    cmd;
  player_pkg::play_state_e play_state;
  logic                    forward;
  logic [`FLASH_ADDR_W-1:0] addr;
  logic                    half;
  logic [`FLASH_ADDR_W-1:0] next_addr;
  logic                    next_half;
  logic                    need_read;

  // ====================
  // Scan code decode
  // ====================
  always_comb
  begin
    cmd = player_pkg::cmd_none;
    if (kbd_data_ready)
    begin
      case (kbd_scan_code)
        `KEY_PLAY:     cmd = player_pkg::cmd_play;
        `KEY_PAUSE:    cmd = player_pkg::cmd_pause;
        `KEY_FORWARD:  cmd = player_pkg::cmd_forward;
        `KEY_BACKWARD: cmd = player_pkg::cmd_backward;
        `KEY_RESTART:  cmd = player_pkg::cmd_restart;
        default:       cmd = player_pkg::cmd_none;
      endcase
    end
  end

  // Next position in the current order
  // Forward plays lower then upper, backward plays upper then lower
  always_comb
  begin
    next_addr = addr;
    next_half = ~half;
    if (forward && half)
      next_addr = (addr == last_addr) ? '0 : addr + 1'b1;
    else if (!forward && !half)
      next_addr = (addr == '0) ? last_addr : addr - 1'b1;
  end

  // First half of a word in the current order needs a flash read
  assign need_read = half ^ forward;

  // ====================
  // Playback FSM
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      play_state <= player_pkg::play_paused;
      forward    <= 1'b1;
      addr       <= '0;
      half       <= 1'b0;
      fetch_req  <= '0;
    end
    else
    begin
      fetch_req.valid <= 1'b0;
      case (cmd)
        player_pkg::cmd_play:
          play_state <= player_pkg::play_playing;
        player_pkg::cmd_pause:
          play_state <= player_pkg::play_paused;
        player_pkg::cmd_forward:
        begin
          // Same word, the half just played comes first again
          if (!forward)
            half <= ~half;
          forward <= 1'b1;
        end
        player_pkg::cmd_backward:
        begin
          if (forward)
            half <= ~half;
          forward <= 1'b0;
        end
        player_pkg::cmd_restart:
        begin
          addr <= forward ? '0 : last_addr;
          half <= ~forward;
        end
        default:
        begin
          if (sample_tick && play_state == player_pkg::play_playing)
          begin
            fetch_req.valid     <= 1'b1;
            fetch_req.need_read <= need_read;
            fetch_req.addr      <= addr;
            fetch_req.half      <= half;
            addr                <= next_addr;
            half                <= next_half;
          end
        end
      endcase
    end
  end

  // Requests only leave while the player is running
  a_no_fetch_paused: assert property (
    @(posedge CLK_50M) disable iff (reset)
    fetch_req.valid |-> play_state == player_pkg::play_playing
  );

endmodule

//--- rtl/sample_timer.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module sample_timer #(
  parameter int unsigned repeat_cycles = `SPEED_REPEAT_CYCLES
) (
  input  logic        CLK_50M,
  input  logic        reset,
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_reset,
  output logic        sample_tick,
  output logic [15:0] divider
);

  localparam logic [15:0] div_default = 16'(`SAMPLE_DIV_DEFAULT);
  localparam logic [15:0] div_min     = 16'(`SAMPLE_DIV_MIN);
  localparam logic [15:0] div_max     = 16'(`SAMPLE_DIV_MAX);
  localparam logic [15:0] div_step    = 16'(`SPEED_STEP);
  localparam int          rep_w       = $clog2(repeat_cycles + 1);

  logic [rep_w-1:0] rep_cnt;
  logic             key_active;
  logic             key_held;
  logic             step_now;
  logic [15:0]      tick_cnt;
  logic [15:0]      period;

  // ====================
  // Key repeat
  // ====================
  assign key_active = speed_up | speed_down;
  // Step on the press, then once per repeat interval
  assign step_now = key_active && (!key_held || rep_cnt == rep_w'(repeat_cycles - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset || !key_active)
    begin
      key_held <= 1'b0;
      rep_cnt  <= '0;
    end
    else
    begin
      key_held <= 1'b1;
      rep_cnt  <= step_now ? '0 : rep_cnt + 1'b1;
    end
  end

  // Speed up shortens the period, clamped at both ends
  always_ff @(posedge CLK_50M)
  begin
    if (reset || speed_reset)
      divider <= div_default;
    else if (step_now && speed_up)
      divider <= (divider < div_min + div_step) ? div_min : divider - div_step;
    else if (step_now)
      divider <= (divider > div_max - div_step) ? div_max : divider + div_step;
  end

  // ====================
  // Tick counter
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      tick_cnt    <= '0;
      period      <= div_default;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == period - 1'b1)
    begin
      tick_cnt    <= '0;
      // New divider takes effect for the next period
      period      <= divider;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  a_divider_range: assert property (
    @(posedge CLK_50M) disable iff (reset)
    divider >= div_min && divider <= div_max
  );

endmodule

//--- rtl/flash_reader.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module flash_reader (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  player_pkg::fetch_req_t fetch_req,
  output player_pkg::flash_req_t flash_req,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::sample_t    sample
);

  typedef enum logic [1:0] {
    rd_idle,
    rd_request,
    rd_wait
  } rd_state_e;

  rd_state_e                rd_state;
  logic [`FLASH_ADDR_W-1:0] rd_addr;
  logic                     rd_half;
  logic [`FLASH_DATA_W-1:0] word_buf;
  logic                     strobe_q;
  logic [`SAMPLE_W-1:0]     data_q;

  // Half 0 is the low sample, half 1 the high one
  function automatic logic [`SAMPLE_W-1:0] pick_half(
    input logic [`FLASH_DATA_W-1:0] word,
    input logic                     half
  );
    return half ? word[`FLASH_DATA_W-1 -: `SAMPLE_W] : word[`SAMPLE_W-1:0];
  endfunction

  assign flash_req.read    = (rd_state == rd_request);
  assign flash_req.address = rd_addr;
  assign sample.strobe     = strobe_q;
  assign sample.data       = data_q;

  // ====================
  // Read protocol
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      rd_state <= rd_idle;
      strobe_q <= 1'b0;
    end
    else
    begin
      strobe_q <= 1'b0;
      case (rd_state)
        rd_idle:
          if (fetch_req.valid && fetch_req.need_read)
            rd_state <= rd_request;
          else if (fetch_req.valid)
            strobe_q <= 1'b1;
        // Held until the flash drops waitrequest
        rd_request:
          if (!flash_rsp.waitrequest)
            rd_state <= rd_wait;
        rd_wait:
          if (flash_rsp.readdatavalid)
          begin
            rd_state <= rd_idle;
            strobe_q <= 1'b1;
          end
        default:
          rd_state <= rd_idle;
      endcase
    end
  end

  // Word buffer and sample data
  always_ff @(posedge CLK_50M)
  begin
    if (fetch_req.valid && fetch_req.need_read)
    begin
      rd_addr <= fetch_req.addr;
      rd_half <= fetch_req.half;
    end
    else if (fetch_req.valid)
      data_q <= pick_half(word_buf, fetch_req.half);
    if (rd_state == rd_wait && flash_rsp.readdatavalid)
    begin
      word_buf <= flash_rsp.readdata;
      data_q   <= pick_half(flash_rsp.readdata, rd_half);
    end
  end

  a_addr_stable: assert property (
    @(posedge CLK_50M) disable iff (reset)
    (flash_req.read && flash_rsp.waitrequest)
      |=> (flash_req.read && $stable(flash_req.address))
  );

  // Sample period must cover the flash latency
  a_no_fetch_busy: assert property (
    @(posedge CLK_50M) disable iff (reset)
    fetch_req.valid |-> rd_state == rd_idle
  );

endmodule

//--- rtl/panel_driver.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module panel_driver (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  player_pkg::sample_t    sample,
  input  logic [15:0]            divider,
  output panel_pkg::led_bar_t    led_volume,
  output panel_pkg::hex_digits_t hex
);

  logic signed [7:0]         level;
  logic [7:0]                magnitude;
  logic [3:0]                lit;
  logic [`LED_BAR_W:0]       bar_full;
  logic [15:0]               div_q;
  logic [`HEX_DIGITS*4-1:0]  hex_value;

  // Segments g..a, active low
  function automatic logic [6:0] seg7(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // ====================
  // Volume bar
  // ====================
  assign level     = sample.data[`SAMPLE_W-1 -: 8];
  assign magnitude = level[7] ? 8'(-level) : 8'(level);
  // 0 to 8 LEDs, 16 steps of magnitude each
  assign lit       = magnitude[7:4];
  assign bar_full  = ((`LED_BAR_W+1)'(1) << lit) - 1'b1;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      led_volume <= '0;
    else if (sample.strobe)
      led_volume <= bar_full[`LED_BAR_W-1:0];
  end

  // Divider readout, two register stages
  assign hex_value = (`HEX_DIGITS*4)'(div_q);

  always_ff @(posedge CLK_50M)
  begin
    div_q <= divider;
    for (int i = 0; i < `HEX_DIGITS; i++)
      hex[i] <= seg7(hex_value[i*4 +: 4]);
  end

endmodule

//--- rtl/ipod_top.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module ipod_top #(
  parameter int unsigned repeat_cycles = `SPEED_REPEAT_CYCLES
) (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  logic [7:0]             kbd_scan_code,
  input  logic                   kbd_data_ready,
  input  logic                   speed_up,
  input  logic                   speed_down,
  input  logic                   speed_reset,
  output player_pkg::flash_req_t flash_req,
  input  player_pkg::flash_rsp_t flash_rsp,
  output player_pkg::sample_t    sample,
  output panel_pkg::led_bar_t    led_volume,
  output panel_pkg::hex_digits_t hex
);

  logic                   sample_tick;
  logic [15:0]            divider;
  player_pkg::fetch_req_t fetch_req;

  // ====================
  // Playback path
  // ====================
  fetch_control fetch_control_inst (
    .CLK_50M        (CLK_50M),
    .reset          (reset),
    .kbd_scan_code  (kbd_scan_code),
    .kbd_data_ready (kbd_data_ready),
    .sample_tick    (sample_tick),
    .fetch_req      (fetch_req)
  );

  sample_timer #(
    .repeat_cycles (repeat_cycles)
  ) sample_timer_inst (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_tick (sample_tick),
    .divider     (divider)
  );

  flash_reader flash_reader_inst (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .fetch_req (fetch_req),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp),
    .sample    (sample)
  );

  // Volume bar and divider readout
  panel_driver panel_driver_inst (
    .CLK_50M    (CLK_50M),
    .reset      (reset),
    .sample     (sample),
    .divider    (divider),
    .led_volume (led_volume),
    .hex        (hex)
  );

endmodule

//--- dv/flash_model.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module flash_model #(
  parameter int unsigned seed = 1
) (
  input  logic                   CLK_50M,
  input  logic                   reset,
  input  player_pkg::flash_req_t flash_req,
  output player_pkg::flash_rsp_t flash_rsp
);

  logic                     busy;
  int unsigned              latency;
  int unsigned              wait_run;
  logic [`FLASH_ADDR_W-1:0] addr_lat;

  // Lower half is the address, upper half its complement
  function automatic logic [`FLASH_DATA_W-1:0] word_at(input logic [`FLASH_ADDR_W-1:0] a);
    return {~a[15:0], a[15:0]};
  endfunction

  initial
  begin
    void'($urandom(seed));
    flash_rsp <= '0;
    flash_rsp.waitrequest <= 1'b1;
    busy = 1'b0;
    latency = 0;
    wait_run = 0;
    addr_lat = '0;
    forever
    begin
      @(posedge CLK_50M);
      if (reset)
      begin
        busy = 1'b0;
        wait_run = 0;
        flash_rsp.readdatavalid <= 1'b0;
        flash_rsp.waitrequest   <= 1'b1;
      end
      else
      begin
        flash_rsp.readdatavalid <= 1'b0;
        if (busy)
        begin
          if (latency == 0)
          begin
            flash_rsp.readdatavalid <= 1'b1;
            flash_rsp.readdata      <= word_at(addr_lat);
            busy = 1'b0;
          end
          else
            latency = latency - 1;
        end
        // Read accepted in a cycle with waitrequest low
        if (flash_req.read && !flash_rsp.waitrequest)
        begin
          busy = 1'b1;
          addr_lat = flash_req.address;
          latency = $urandom_range(19, 0);
        end
        // Short random stalls of at most two cycles in a row
        if (wait_run >= 2 || $urandom_range(2, 0) != 0)
        begin
          flash_rsp.waitrequest <= 1'b0;
          wait_run = 0;
        end
        else
        begin
          flash_rsp.waitrequest <= 1'b1;
          wait_run = wait_run + 1;
        end
      end
    end
  end

endmodule

//--- dv/ipod_tb.sv
`timescale 1ns/1ps
`include "ipod_settings.svh"

module ipod_tb;

  localparam logic [`FLASH_ADDR_W-1:0] last_addr = `FLASH_LAST_ADDR;
  localparam int hold_clamp = 820000;
  localparam int hold_short = 650;
  localparam int sample_total = 74;
  localparam int watchdog_cycles = sample_total * `SAMPLE_DIV_DEFAULT * 2
                                   + 2 * hold_clamp + hold_short + 200000;

  logic                   CLK_50M;
  logic                   reset;
  logic [7:0]             kbd_scan_code;
  logic                   kbd_data_ready;
  logic                   speed_up;
  logic                   speed_down;
  logic                   speed_reset;
  player_pkg::flash_req_t flash_req;
  player_pkg::flash_rsp_t flash_rsp;
  player_pkg::sample_t    sample;
  panel_pkg::led_bar_t    led_volume;
  panel_pkg::hex_digits_t hex;

  // Reference position and checker state
  logic [`FLASH_ADDR_W-1:0] ref_addr;
  logic                     ref_half;
  logic                     ref_forward;
  int                       error_count;
  int                       led_errors;
  int                       strobe_count;
  int                       read_count;
  int                       cycle;
  logic [15:0]              last_data;
  logic                     led_pending;
  panel_pkg::led_bar_t      led_expect;
  logic                     interval_check;
  int                       interval_seen;
  int                       exp_div;
  int                       t_prev1;
  int                       t_prev2;
  int                       tests_failed;
  int                       tests_run;

  ipod_top #(
    .repeat_cycles (200)
  ) dut0 (
    .CLK_50M        (CLK_50M),
    .reset          (reset),
    .kbd_scan_code  (kbd_scan_code),
    .kbd_data_ready (kbd_data_ready),
    .speed_up       (speed_up),
    .speed_down     (speed_down),
    .speed_reset    (speed_reset),
    .flash_req      (flash_req),
    .flash_rsp      (flash_rsp),
    .sample         (sample),
    .led_volume     (led_volume),
    .hex            (hex)
  );

  flash_model #(
    .seed (87880)
  ) flash0 (
    .CLK_50M   (CLK_50M),
    .reset     (reset),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  // ====================
  // Reference functions
  // ====================
  function automatic logic [15:0] expected_sample(input logic [`FLASH_ADDR_W-1:0] a,
                                                  input logic half);
    return half ? ~a[15:0] : a[15:0];
  endfunction

  function automatic panel_pkg::led_bar_t expected_led(input logic [15:0] data);
    int mag;
    int n;
    mag = data[15] ? 256 - int'(data[15:8]) : int'(data[15:8]);
    n = mag / 16;
    return 8'((9'd1 << n) - 1);
  endfunction

  function automatic panel_pkg::hex_digits_t expected_hex(input int value);
    logic [6:0] on_segs [16];
    panel_pkg::hex_digits_t digits;
    on_segs = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    for (int i = 0; i < `HEX_DIGITS; i++)
      digits[i] = ~on_segs[(value >> (4 * i)) & 15];
    return digits;
  endfunction

  // Step the reference one sample in the current order
  task automatic advance_ref();
    if (ref_forward && ref_half)
      ref_addr = (ref_addr == last_addr) ? '0 : ref_addr + 1'b1;
    else if (!ref_forward && !ref_half)
      ref_addr = (ref_addr == '0) ? last_addr : ref_addr - 1'b1;
    ref_half = ~ref_half;
  endtask

  // ====================
  // Clock and watchdog
  // ====================
  initial
  begin
    CLK_50M = 1'b0;
    forever
      #10 CLK_50M = ~CLK_50M;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge CLK_50M);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  // Checker samples on the falling edge where outputs are stable
  always @(negedge CLK_50M)
  begin
    cycle = cycle + 1;
    if (led_pending)
    begin
      led_pending = 1'b0;
      assert (led_volume == led_expect)
      else
      begin
        $display("FAIL %0t led_volume expected %h got %h", $time, led_expect, led_volume);
        error_count++;
        led_errors++;
      end
    end
    if (!reset && flash_req.read)
      read_count++;
    if (!reset && sample.strobe)
    begin
      assert (sample.data == expected_sample(ref_addr, ref_half))
      else
      begin
        $display("FAIL %0t sample.data expected %h got %h", $time,
                 expected_sample(ref_addr, ref_half), sample.data);
        error_count++;
      end
      if (interval_check)
      begin
        interval_seen++;
        if (interval_seen > 3)
        begin
          assert ((cycle - t_prev2) >= 2 * exp_div - 40
                  && (cycle - t_prev2) <= 2 * exp_div + 40)
          else
          begin
            $display("FAIL %0t strobe interval expected %0d got %0d", $time,
                     exp_div, (cycle - t_prev2) / 2);
            error_count++;
          end
        end
      end
      t_prev2 = t_prev1;
      t_prev1 = cycle;
      last_data = sample.data;
      led_expect = expected_led(expected_sample(ref_addr, ref_half));
      led_pending = 1'b1;
      advance_ref();
      strobe_count++;
    end
  end

  // ====================
  // Stimulus tasks
  // ====================
  task automatic send_key(input logic [7:0] code);
    @(posedge CLK_50M);
    #2;
    kbd_scan_code = code;
    kbd_data_ready = 1'b1;
    @(posedge CLK_50M);
    #2;
    kbd_data_ready = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK_50M);
    #2;
  endtask

  task automatic wait_strobes(input int n);
    int target;
    target = strobe_count + n;
    wait (strobe_count >= target);
    idle_cycles(2);
  endtask

  // Pause and let any read still in flight finish
  task automatic pause_and_drain();
    send_key(`KEY_PAUSE);
    idle_cycles(100);
  endtask

  task automatic change_direction(input logic fwd);
    send_key(fwd ? `KEY_FORWARD : `KEY_BACKWARD);
    if (fwd != ref_forward)
      ref_half = ~ref_half;
    ref_forward = fwd;
  endtask

  task automatic restart_ref();
    send_key(`KEY_RESTART);
    ref_addr = ref_forward ? '0 : last_addr;
    ref_half = ~ref_forward;
  endtask

  task automatic hold_key(input int which, input int n);
    @(posedge CLK_50M);
    #2;
    if (which == 0)
      speed_up = 1'b1;
    else
      speed_down = 1'b1;
    idle_cycles(n);
    speed_up = 1'b0;
    speed_down = 1'b0;
  endtask

  task automatic pulse_speed_reset();
    speed_reset = 1'b1;
    idle_cycles(1);
    speed_reset = 1'b0;
    idle_cycles(5);
  endtask

  task automatic check_hex(input int value);
    assert (hex == expected_hex(value))
    else
    begin
      $display("FAIL %0t hex expected %h got %h", $time, expected_hex(value), hex);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before)
      $display("test %s: ok", name);
    else
    begin
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
      tests_failed++;
    end
  endtask

  // ====================
  // Test sequence
  // ====================
  initial
  begin
    int e0;
    int strobes_before;
    kbd_scan_code = 8'h00;
    kbd_data_ready = 1'b0;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_reset = 1'b0;
    reset = 1'b1;
    ref_addr = '0;
    ref_half = 1'b0;
    ref_forward = 1'b1;
    error_count = 0;
    led_errors = 0;
    strobe_count = 0;
    read_count = 0;
    cycle = 0;
    led_pending = 1'b0;
    interval_check = 1'b0;
    interval_seen = 0;
    exp_div = `SAMPLE_DIV_DEFAULT;
    t_prev1 = 0;
    t_prev2 = 0;
    tests_failed = 0;
    tests_run = 0;
    repeat (8) @(posedge CLK_50M);
    #2;
    reset = 1'b0;

    // Quiet after reset
    e0 = error_count;
    idle_cycles(3000);
    assert (strobe_count == 0 && read_count == 0)
    else
    begin
      $display("Strobes or flash reads appeared while paused after reset");
      error_count++;
    end
    assert (led_volume == '0)
    else
    begin
      $display("FAIL %0t led_volume expected 00 got %h", $time, led_volume);
      error_count++;
    end
    check_hex(`SAMPLE_DIV_DEFAULT);
    report_test("reset", e0);

    // Forward playback under back-pressure
    e0 = error_count;
    send_key(`KEY_PLAY);
    wait_strobes(40);
    report_test("play_forward", e0);

    // Pause, backward, restart, forward
    e0 = error_count;
    pause_and_drain();
    strobes_before = strobe_count;
    idle_cycles(3000);
    assert (strobe_count == strobes_before)
    else
    begin
      $display("Strobes continued after pause");
      error_count++;
    end
    change_direction(1'b0);
    send_key(`KEY_PLAY);
    wait_strobes(10);
    pause_and_drain();
    restart_ref();
    send_key(`KEY_PLAY);
    wait_strobes(1);
    assert (last_data == expected_sample(last_addr, 1'b1))
    else
    begin
      $display("FAIL %0t sample.data expected %h got %h", $time,
               expected_sample(last_addr, 1'b1), last_data);
      error_count++;
    end
    wait_strobes(5);
    pause_and_drain();
    change_direction(1'b1);
    restart_ref();
    send_key(`KEY_PLAY);
    wait_strobes(1);
    assert (last_data == 16'h0000)
    else
    begin
      $display("FAIL %0t sample.data expected 0000 got %h", $time, last_data);
      error_count++;
    end
    wait_strobes(5);
    pause_and_drain();
    report_test("transport", e0);

    // Speed step with key repeat, then strobe spacing
    e0 = error_count;
    hold_key(0, hold_short);
    exp_div = `SAMPLE_DIV_DEFAULT - (1 + (hold_short - 1) / 200) * `SPEED_STEP;
    idle_cycles(5);
    check_hex(exp_div);
    interval_seen = 0;
    interval_check = 1'b1;
    send_key(`KEY_PLAY);
    wait_strobes(12);
    interval_check = 1'b0;
    pause_and_drain();
    pulse_speed_reset();
    check_hex(`SAMPLE_DIV_DEFAULT);
    report_test("speed", e0);

    // LED bar is checked on every strobe above
    tests_run++;
    if (led_errors == 0)
      $display("test led_bar: ok");
    else
    begin
      $display("test led_bar: failed with %0d errors", led_errors);
      tests_failed++;
    end

    // Divider clamps at both limits
    e0 = error_count;
    hold_key(1, hold_clamp);
    idle_cycles(5);
    check_hex(`SAMPLE_DIV_MAX);
    hold_key(0, hold_clamp);
    idle_cycles(5);
    check_hex(`SAMPLE_DIV_MIN);
    pulse_speed_reset();
    check_hex(`SAMPLE_DIV_DEFAULT);
    report_test("clamp", e0);

    $display("tests run %0d, failed %0d, errors %0d, strobes %0d",
             tests_run, tests_failed, error_count, strobe_count);
    if (error_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- src.f
+incdir+rtl
rtl/player_pkg.sv
rtl/panel_pkg.sv
rtl/fetch_control.sv
rtl/sample_timer.sv
rtl/flash_reader.sv
rtl/panel_driver.sv
rtl/ipod_top.sv
dv/flash_model.sv
dv/ipod_tb.sv
